//--- design/sys_pkg.sv
// shared constants and types for the host-debug memory subsystem
// imported by every stage that needs the address map, serial timing or command codes
package sys_pkg;

	// bus address and RAM geometry
	localparam int addr_w = 16;
	localparam int ram_addr_w = 12;

	// serial line timing in clk cycles
	localparam int clks_per_bit = 16;

	// first byte of each host command
	localparam logic [7:0] cmd_write = 8'h57;
	localparam logic [7:0] cmd_read = 8'h52;

	// top two address bits that select the I/O window
	localparam logic [1:0] io_region = 2'b11;

	typedef logic [addr_w-1:0] bus_addr_t;
	typedef logic [7:0] byte_t;

endpackage

//--- design/mem_req_if.sv
// request channel from the command decoder to the memory stage
// four-phase req/ack, with wr, addr and wdata held stable while req is up
`timescale 1ns/1ps

interface mem_req_if;
	import sys_pkg::*;

	logic req;
	logic ack;
	logic wr;
	bus_addr_t addr;
	byte_t wdata;

	modport hci_cmd (
		output req,
		output wr,
		output addr,
		output wdata,
		input ack
	);

	modport mem_stage (
		input req,
		input wr,
		input addr,
		input wdata,
		output ack
	);

endinterface

//--- design/uart_rx.sv
// serial receiver, 8N1 with mid-bit sampling
// each good byte is offered on rx_data by four-phase req/ack
`timescale 1ns/1ps

module uart_rx (
	input logic clk,
	input logic rst,
	input logic rx,
	output logic rx_req,
	input logic rx_ack,
	output sys_pkg::byte_t rx_data
);
	import sys_pkg::*;

	typedef logic [$clog2(clks_per_bit)-1:0] tick_t;
	typedef enum logic [1:0] {st_idle, st_start, st_bits, st_stop} rx_state_t;

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	tick_t cnt;
	logic [2:0] bit_idx;
	byte_t shift;
	logic stop_hit;
	logic tick_half;
	logic tick_last;
	logic load;

	assign tick_half = (cnt == tick_t'(clks_per_bit / 2 - 1));
	assign tick_last = (cnt == tick_t'(clks_per_bit - 1));
	// byte is dropped if the previous one is still in its handshake
	assign load = stop_hit && !rx_req && !rx_ack;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			state <= st_idle;
			cnt <= '0;
			bit_idx <= '0;
			stop_hit <= 1'b0;
			rx_req <= 1'b0;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			stop_hit <= 1'b0;
			cnt <= cnt + 1'b1;
			case (state)
				st_idle: begin
					cnt <= '0;
					if (!rx_sync)
						state <= st_start;
				end
				st_start: begin
					// glitch shorter than half a bit goes back to idle
					if (tick_half) begin
						cnt <= '0;
						state <= rx_sync ? st_idle : st_bits;
					end
				end
				st_bits: begin
					if (tick_last) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= st_stop;
					end
				end
				default: begin
					if (tick_last) begin
						stop_hit <= rx_sync;
						state <= st_idle;
					end
				end
			endcase
			if (load)
				rx_req <= 1'b1;
			else if (rx_ack)
				rx_req <= 1'b0;
		end
	end

	// lsb arrives first, so shift in from the top
	always_ff @(posedge clk) begin
		if (state == st_bits && tick_last)
			shift <= {rx_sync, shift[7:1]};
		if (load)
			rx_data <= shift;
	end

endmodule

//--- design/hci_cmd.sv
// host command decoder
// collects opcode, address and write data bytes, then issues one memory request
`timescale 1ns/1ps

module hci_cmd (
	input logic clk,
	input logic rst,
	input logic rx_req,
	output logic rx_ack,
	input sys_pkg::byte_t rx_data,
	mem_req_if.hci_cmd mem
);
	import sys_pkg::*;

	typedef enum logic [2:0] {
		st_op,
		st_addr_hi,
		st_addr_lo,
		st_data,
		st_mem,
		st_done
	} cmd_state_t;

	cmd_state_t state;
	logic listening;
	logic take;

	// no bytes are taken while a memory handshake is in flight
	assign listening = (state != st_mem) && (state != st_done);
	assign take = listening && rx_req && !rx_ack;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= st_op;
			rx_ack <= 1'b0;
			mem.req <= 1'b0;
		end else begin
			if (take)
				rx_ack <= 1'b1;
			else if (!rx_req)
				rx_ack <= 1'b0;

			case (state)
				st_op: begin
					// unknown opcodes are acked and then ignored
					if (take && (rx_data == cmd_write || rx_data == cmd_read))
						state <= st_addr_hi;
				end
				st_addr_hi: begin
					if (take)
						state <= st_addr_lo;
				end
				st_addr_lo: begin
					if (take) begin
						if (mem.wr) begin
							state <= st_data;
						end else begin
							mem.req <= 1'b1;
							state <= st_mem;
						end
					end
				end
				st_data: begin
					if (take) begin
						mem.req <= 1'b1;
						state <= st_mem;
					end
				end
				st_mem: begin
					if (mem.ack) begin
						mem.req <= 1'b0;
						state <= st_done;
					end
				end
				default: begin
					// wait for the memory stage to release ack
					if (!mem.ack)
						state <= st_op;
				end
			endcase
		end
	end

	// request payload, only touched while collecting bytes
	always_ff @(posedge clk) begin
		if (take) begin
			case (state)
				st_op: mem.wr <= (rx_data == cmd_write);
				st_addr_hi: mem.addr[addr_w-1 -: 8] <= rx_data;
				st_addr_lo: mem.addr[7:0] <= rx_data;
				st_data: mem.wdata <= rx_data;
				default: ;
			endcase
		end
	end

endmodule

//--- design/mem_stage.sv
// memory stage: splits RAM from the I/O window and returns read bytes
// a read is acked to the decoder only after the transmitter has taken the reply
`timescale 1ns/1ps

module mem_stage (
	input logic clk,
	input logic rst,
	mem_req_if.mem_stage mem,
	output logic tx_req,
	input logic tx_ack,
	output sys_pkg::byte_t tx_data,
	output logic led
);
	import sys_pkg::*;

	typedef enum logic [1:0] {st_idle, st_read, st_tx, st_ack} mem_state_t;

	mem_state_t state;
	byte_t ram [2**ram_addr_w];
	byte_t ram_q;
	byte_t dbg_reg;
	byte_t wr_count;
	logic q_io_sel;
	logic is_io;
	logic start;
	logic [ram_addr_w-1:0] ram_idx;

	// top two bits both set selects I/O, the rest aliases into RAM
	assign is_io = (mem.addr[addr_w-1 -: 2] == io_region);
	assign ram_idx = mem.addr[ram_addr_w-1:0];
	assign start = (state == st_idle) && mem.req && !tx_ack;
	assign led = dbg_reg[0];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= st_idle;
			mem.ack <= 1'b0;
			tx_req <= 1'b0;
			dbg_reg <= '0;
			wr_count <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (start) begin
						if (mem.wr) begin
							wr_count <= wr_count + 1'b1;
							if (is_io)
								dbg_reg <= mem.wdata;
							mem.ack <= 1'b1;
							state <= st_ack;
						end else begin
							state <= st_read;
						end
					end
				end
				st_read: begin
					tx_req <= 1'b1;
					state <= st_tx;
				end
				st_tx: begin
					if (tx_ack) begin
						tx_req <= 1'b0;
						mem.ack <= 1'b1;
						state <= st_ack;
					end
				end
				default: begin
					if (!mem.req) begin
						mem.ack <= 1'b0;
						state <= st_idle;
					end
				end
			endcase
		end
	end

	// RAM write port and registered read, with the I/O select delayed to match
	always_ff @(posedge clk) begin
		if (start && mem.wr && !is_io)
			ram[ram_idx] <= mem.wdata;
		if (start && !mem.wr) begin
			ram_q <= ram[ram_idx];
			q_io_sel <= is_io;
		end
		if (state == st_read)
			tx_data <= q_io_sel ? wr_count : ram_q;
	end

endmodule

//--- design/uart_tx.sv
// serial transmitter, 8N1, lsb first
// takes one reply byte per four-phase req/ack and shifts it out on tx
`timescale 1ns/1ps

module uart_tx (
	input logic clk,
	input logic rst,
	input logic tx_req,
	output logic tx_ack,
	input sys_pkg::byte_t tx_data,
	output logic tx
);
	import sys_pkg::*;

	typedef logic [$clog2(clks_per_bit)-1:0] tick_t;

	logic [9:0] frame;
	tick_t cnt;
	logic [3:0] bit_cnt;
	logic busy;
	logic tick_last;

	assign tick_last = (cnt == tick_t'(clks_per_bit - 1));
	// ones shift in behind the frame, so the line rests high
	assign tx = frame[0];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			frame <= '1;
			cnt <= '0;
			bit_cnt <= '0;
			busy <= 1'b0;
			tx_ack <= 1'b0;
		end else begin
			if (!busy) begin
				if (tx_req && !tx_ack) begin
					// stop, data, start
					frame <= {1'b1, tx_data, 1'b0};
					cnt <= '0;
					bit_cnt <= '0;
					busy <= 1'b1;
					tx_ack <= 1'b1;
				end
			end else begin
				cnt <= cnt + 1'b1;
				if (tick_last) begin
					cnt <= '0;
					frame <= {1'b1, frame[9:1]};
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 4'd9)
						busy <= 1'b0;
				end
			end
			if (tx_ack && !tx_req)
				tx_ack <= 1'b0;
		end
	end

endmodule

//--- design/sys_top.sv
// board top level: reset synchronizer and the four pipeline stages
// host commands arrive on rx, read replies leave on tx, led shows debug register bit 0
`timescale 1ns/1ps

module sys_top (
	input logic clk,
	input logic btnC,
	input logic rx,
	output logic tx,
	output logic led
);
	import sys_pkg::*;

	logic rst;
	logic rst_delay;
	logic rx_req;
	logic rx_ack;
	byte_t rx_data;
	logic tx_req;
	logic tx_ack;
	byte_t tx_data;

	mem_req_if mem_bus ();

	// asserted at once by btnC, released two edges after it falls
	always_ff @(posedge clk or posedge btnC) begin
		if (btnC) begin
			rst <= 1'b1;
			rst_delay <= 1'b1;
		end else begin
			rst_delay <= 1'b0;
			rst <= rst_delay;
		end
	end

	uart_rx rx0 (
		.clk(clk),
		.rst(rst),
		.rx(rx),
		.rx_req(rx_req),
		.rx_ack(rx_ack),
		.rx_data(rx_data)
	);

	hci_cmd hci0 (
		.clk(clk),
		.rst(rst),
		.rx_req(rx_req),
		.rx_ack(rx_ack),
		.rx_data(rx_data),
		.mem(mem_bus.hci_cmd)
	);

	mem_stage mem0 (
		.clk(clk),
		.rst(rst),
		.mem(mem_bus.mem_stage),
		.tx_req(tx_req),
		.tx_ack(tx_ack),
		.tx_data(tx_data),
		.led(led)
	);

	uart_tx tx0 (
		.clk(clk),
		.rst(rst),
		.tx_req(tx_req),
		.tx_ack(tx_ack),
		.tx_data(tx_data),
		.tx(tx)
	);

endmodule

//--- test/sys_top_props.sv
// handshake and serial line checks, bound into sys_top by the testbench
`timescale 1ns/1ps

module sys_top_props (
	input logic clk,
	input logic rst,
	input logic rx_req,
	input logic rx_ack,
	input logic mem_req,
	input logic mem_ack,
	input logic tx_req,
	input logic tx_ack,
	input logic tx_busy,
	input logic tx,
	input logic led
);

	// a raised req waits for its ack
	rx_req_hold: assert property (@(posedge clk) disable iff (rst)
		rx_req && !rx_ack |=> rx_req)
		else $error("rx_req dropped before rx_ack");
	mem_req_hold: assert property (@(posedge clk) disable iff (rst)
		mem_req && !mem_ack |=> mem_req)
		else $error("memory req dropped before its ack");
	tx_req_hold: assert property (@(posedge clk) disable iff (rst)
		tx_req && !tx_ack |=> tx_req)
		else $error("tx_req dropped before tx_ack");

	// ack comes down only once req is gone
	rx_ack_hold: assert property (@(posedge clk) disable iff (rst)
		rx_ack && rx_req |=> rx_ack)
		else $error("rx_ack dropped while rx_req was high");
	mem_ack_hold: assert property (@(posedge clk) disable iff (rst)
		mem_ack && mem_req |=> mem_ack)
		else $error("memory ack dropped while req was high");
	tx_ack_hold: assert property (@(posedge clk) disable iff (rst)
		tx_ack && tx_req |=> tx_ack)
		else $error("tx_ack dropped while tx_req was high");

	tx_idle_high: assert property (@(posedge clk) !tx_busy |-> tx)
		else $error("tx low while the transmitter is idle");
	led_in_reset: assert property (@(posedge clk) rst |-> !led)
		else $error("led high during reset");

endmodule

//--- test/sys_top_tb.sv
// testbench for sys_top: sends host commands on rx and checks the replies on tx
// stimulus comes from a seeded LFSR, expected bytes from a reference model of the address map
`timescale 1ns/1ps

module sys_top_tb;
	import sys_pkg::*;

	localparam int reply_timeout = 2000;
	localparam int led_timeout = 64;

	logic clk;
	logic btnC;
	logic rx;
	logic tx;
	logic led;

	byte_t ref_mem [2**ram_addr_w];
	byte_t ref_count;
	logic ref_led;
	bus_addr_t written [$];
	logic [15:0] lfsr;
	int value_errors;
	int timeouts;

	sys_top dut0 (.clk(clk), .btnC(btnC), .rx(rx), .tx(tx), .led(led));

	bind sys_top sys_top_props props0 (
		.clk(clk), .rst(rst), .rx_req(rx_req), .rx_ack(rx_ack),
		.mem_req(mem_bus.req), .mem_ack(mem_bus.ack), .tx_req(tx_req),
		.tx_ack(tx_ack), .tx_busy(tx0.busy), .tx(tx), .led(led)
	);

	always #4 clk = ~clk;

	// galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	task automatic send_byte(input byte_t b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			rx = frame[i];
			repeat (clks_per_bit - 1) @(negedge clk);
		end
	endtask

	task automatic send_cmd(input byte_t op, input bus_addr_t addr, input byte_t data,
			input logic with_data);
		send_byte(op);
		send_byte(addr[15:8]);
		send_byte(addr[7:0]);
		if (with_data)
			send_byte(data);
		// one idle bit between commands
		repeat (clks_per_bit) @(negedge clk);
	endtask

	task automatic write_mem(input bus_addr_t addr, input byte_t data);
		send_cmd(cmd_write, addr, data, 1'b1);
		ref_count = ref_count + 8'd1;
		if (addr[15:14] == io_region) begin
			ref_led = data[0];
		end else begin
			ref_mem[addr[11:0]] = data;
			written.push_back(addr);
		end
	endtask

	task automatic recv_byte(output byte_t b, output logic ok);
		int t;
		ok = 1'b0;
		b = '0;
		t = 0;
		@(negedge clk);
		while (tx !== 1'b0 && t < reply_timeout) begin
			@(negedge clk);
			t++;
		end
		if (tx !== 1'b0) begin
			$display("timeout: no reply start bit on tx within %0d cycles", reply_timeout);
			timeouts++;
			return;
		end
		// move to the middle of the start bit, then one bit period per sample
		repeat (clks_per_bit / 2) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			repeat (clks_per_bit) @(negedge clk);
			b[i] = tx;
		end
		repeat (clks_per_bit) @(negedge clk);
		assert (tx === 1'b1) else begin
			value_errors++;
			$display("[ERROR] %0t: reply stop bit is low", $time);
		end
		ok = 1'b1;
	endtask

	task automatic check_byte(input byte_t got, input byte_t exp, input string what);
		assert (got === exp) else begin
			value_errors++;
			$display("[ERROR] %0t: %s returned %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic read_check(input bus_addr_t addr, input byte_t exp, input string what);
		byte_t got;
		logic ok;
		fork
			send_cmd(cmd_read, addr, 8'h00, 1'b0);
			recv_byte(got, ok);
		join
		if (ok)
			check_byte(got, exp, what);
	endtask

	task automatic wait_led(input logic exp);
		int t;
		t = 0;
		while (led !== exp && t < led_timeout) begin
			@(negedge clk);
			t++;
		end
		assert (led === exp) else begin
			value_errors++;
			$display("[ERROR] %0t: led is %b, expected %b", $time, led, exp);
		end
	endtask

	task automatic check_quiet(input int cycles, input logic exp_led);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			assert (tx === 1'b1 && led === exp_led) else begin
				value_errors++;
				$display("[ERROR] %0t: tx %b led %b on a quiet line", $time, tx, led);
			end
		end
	endtask

	initial begin
		bus_addr_t a;
		logic [15:0] r;
		byte_t got [3];
		logic ok [3];
		bus_addr_t rd [3];
		clk = 1'b0;
		btnC = 1'b1;
		rx = 1'b1;
		lfsr = 16'd25;
		ref_count = '0;
		ref_led = 1'b0;
		value_errors = 0;
		timeouts = 0;
		repeat (5) @(negedge clk);
		btnC = 1'b0;
		check_quiet(200, 1'b0);

		// random RAM writes outside the I/O window and then a few overwrites
		for (int i = 0; i < 8; i++) begin
			draw_bits(16, a);
			if (a[15:14] == io_region)
				a[15] = 1'b0;
			draw_bits(8, r);
			write_mem(a, r[7:0]);
		end
		for (int i = 0; i < 3; i++) begin
			draw_bits(8, r);
			write_mem(written[2 * i], r[7:0]);
		end
		foreach (written[i])
			read_check(written[i], ref_mem[written[i][11:0]], "RAM read");

		// bits 13:12 are above the RAM index and leave the region bits alone
		for (int i = 0; i < 3; i++) begin
			a = {written[i][15:14], ~written[i][13:12], written[i][11:0]};
			read_check(a, ref_mem[a[11:0]], "aliased read");
		end

		// led goes high and then low again with data bit 0 of each I/O write
		draw_bits(14, r);
		draw_bits(8, a);
		write_mem({io_region, r[13:0]}, a[7:0] | 8'h01);
		wait_led(ref_led);
		draw_bits(14, r);
		write_mem({io_region, r[13:0]}, 8'h5a);
		wait_led(ref_led);
		draw_bits(14, r);
		read_check({io_region, r[13:0]}, ref_count, "I/O read");

		// an unknown opcode is dropped and the read behind it answers once
		send_byte(8'ha5);
		read_check(written[1], ref_mem[written[1][11:0]], "read after bad opcode");
		check_quiet(12 * clks_per_bit, ref_led);

		// replies to back-to-back reads keep command order
		for (int k = 0; k < 3; k++)
			rd[k] = written[k + 3];
		fork
			begin
				for (int k = 0; k < 3; k++)
					send_cmd(cmd_read, rd[k], 8'h00, 1'b0);
			end
			begin
				for (int k = 0; k < 3; k++)
					recv_byte(got[k], ok[k]);
			end
		join
		for (int k = 0; k < 3; k++) begin
			if (ok[k])
				check_byte(got[k], ref_mem[rd[k][11:0]], "back-to-back read");
		end

		$display("value errors: %0d, timeouts: %0d", value_errors, timeouts);
		if (value_errors == 0 && timeouts == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- sys_top.f
design/sys_pkg.sv
design/mem_req_if.sv
design/uart_rx.sv
design/hci_cmd.sv
design/mem_stage.sv
design/uart_tx.sv
design/sys_top.sv
test/sys_top_props.sv
test/sys_top_tb.sv

//--- Makefile
TOP = sys_top_tb

all: run

build: obj_dir/V$(TOP)

obj_dir/V$(TOP): sys_top.f design/*.sv test/*.sv
	verilator --binary --timing --assert -f sys_top.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^all tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run clean
